// ==== src/cpuTypesPkg.sv ====
// MIPS32 subset only; no HALT opcode enum since halt is matched on the whole all-ones word
package cpuTypesPkg;

  // word and field widths
  localparam int WORD_W = 32;
  localparam int REG_W  = 5;
  localparam int IMM_W  = 16;
  localparam int SHAM_W = 5;
  localparam int ADDR_W = 26;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REG_W-1:0]  regbits_t;

  // fetch starts here after rst
  localparam word_t PC_INIT    = '0;
  localparam word_t HALT_INSTR = '1;

  // major opcodes, supported subset only
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    XORI  = 6'b001110,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011
  } opcode_t;

  // r-type function field
  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    SRL  = 6'b000010,
    JR   = 6'b001000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    XOR  = 6'b100110,
    NOR  = 6'b100111,
    SLT  = 6'b101010,
    SLTU = 6'b101011
  } funct_t;

  // alu codes
  typedef enum logic [3:0] {
    ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
    ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
  } aluop_t;

  // next pc class
  typedef enum logic [2:0] {OJR, OBEQ, OBNE, OJ, OJAL, ONEXT} opfunc_t;

  // mux selects
  typedef enum logic [1:0] {RD, RT, R31} regDst_t;
  typedef enum logic [1:0] {ALUO, DLOAD, PORTB, NPC} memToReg_t;
  typedef enum logic [1:0] {ZEROEXT, SIGNEXT, SHAMEXT, LUIEXT} extOp_t;

  // instruction formats
  typedef struct packed {
    opcode_t           opcode;
    regbits_t          rs;
    regbits_t          rt;
    regbits_t          rd;
    logic [SHAM_W-1:0] shamt;
    funct_t            funct;
  } rFormat_t;

  typedef struct packed {
    opcode_t          opcode;
    regbits_t         rs;
    regbits_t         rt;
    logic [IMM_W-1:0] imm;
  } iFormat_t;

  typedef struct packed {
    opcode_t           opcode;
    logic [ADDR_W-1:0] addr;
  } jFormat_t;

  // one fetched word, three views
  typedef union packed {
    rFormat_t r;
    iFormat_t i;
    jFormat_t j;
  } instr_t;

endpackage

// ==== src/cpuIfs.sv ====
// core-internal buses only; aluIf carries CLK purely so the alu can hold a clocked check
`timescale 1ns/1ps

interface registerFileIf;
  import cpuTypesPkg::*;

  logic     wen;
  regbits_t wsel;
  regbits_t rsel1;
  regbits_t rsel2;
  word_t    wdat;
  word_t    rdat1;
  word_t    rdat2;

  // register file side
  modport rf (
    input  wen, wsel, rsel1, rsel2, wdat,
    output rdat1, rdat2
  );

  // datapath side
  modport dp (
    output wen, wsel, rsel1, rsel2, wdat,
    input  rdat1, rdat2
  );
endinterface

interface aluIf (input logic CLK);
  import cpuTypesPkg::*;

  word_t  portA;
  word_t  portB;
  aluop_t aluOp;
  word_t  portO;
  logic   flagNegative;
  logic   flagOverflow;
  logic   flagZero;

  modport alu (
    input  CLK, portA, portB, aluOp,
    output portO, flagNegative, flagOverflow, flagZero
  );

  modport dp (
    output portA, portB, aluOp,
    input  portO, flagNegative, flagOverflow, flagZero
  );
endinterface

interface controlUnitIf;
  import cpuTypesPkg::*;

  instr_t    instr;
  opfunc_t   opfunc;
  regDst_t   regDst;
  logic      aluSrc;
  memToReg_t memToReg;
  logic      regWen;
  logic      dRen;
  logic      dWen;
  aluop_t    aluOp;
  extOp_t    extOp;
  logic      halt;

  modport cu (
    input  instr,
    output opfunc, regDst, aluSrc, memToReg, regWen, dRen, dWen, aluOp, extOp, halt
  );

  modport dp (
    output instr,
    input  opfunc, regDst, aluSrc, memToReg, regWen, dRen, dWen, aluOp, extOp, halt
  );
endinterface

// ==== src/controlUnit.sv ====
// purely combinational decode; unsupported encodings become a no-op with no writes
`timescale 1ns/1ps

module controlUnit (
  controlUnitIf.cu cuif
);
  import cpuTypesPkg::*;

  always_comb begin
    // no-op defaults
    cuif.opfunc   = ONEXT;
    cuif.regDst   = RD;
    cuif.aluSrc   = 1'b0;
    cuif.memToReg = ALUO;
    cuif.regWen   = 1'b0;
    cuif.dRen     = 1'b0;
    cuif.dWen     = 1'b0;
    cuif.aluOp    = ALU_ADD;
    cuif.extOp    = ZEROEXT;
    // halt matched on the full word
    cuif.halt     = (cuif.instr == HALT_INSTR);

    case (cuif.instr.r.opcode)
      RTYPE: begin
        cuif.regDst = RD;
        cuif.regWen = 1'b1;
        case (cuif.instr.r.funct)
          SLL: begin
            // shamt goes in through port b
            cuif.aluOp  = ALU_SLL;
            cuif.aluSrc = 1'b1;
            cuif.extOp  = SHAMEXT;
          end
          SRL: begin
            cuif.aluOp  = ALU_SRL;
            cuif.aluSrc = 1'b1;
            cuif.extOp  = SHAMEXT;
          end
          ADDU: cuif.aluOp = ALU_ADD;
          SUBU: cuif.aluOp = ALU_SUB;
          AND:  cuif.aluOp = ALU_AND;
          OR:   cuif.aluOp = ALU_OR;
          XOR:  cuif.aluOp = ALU_XOR;
          NOR:  cuif.aluOp = ALU_NOR;
          SLT:  cuif.aluOp = ALU_SLT;
          SLTU: cuif.aluOp = ALU_SLTU;
          JR: begin
            cuif.opfunc = OJR;
            cuif.regWen = 1'b0;
          end
          default: cuif.regWen = 1'b0;
        endcase
      end
      // immediates write rt
      ADDIU, SLTI, ANDI, ORI, XORI, LUI, LW: begin
        cuif.regDst = RT;
        cuif.regWen = 1'b1;
        cuif.aluSrc = 1'b1;
        case (cuif.instr.r.opcode)
          ADDIU: cuif.extOp = SIGNEXT;
          SLTI: begin
            cuif.extOp = SIGNEXT;
            cuif.aluOp = ALU_SLT;
          end
          ANDI: cuif.aluOp = ALU_AND;
          ORI:  cuif.aluOp = ALU_OR;
          XORI: cuif.aluOp = ALU_XOR;
          LUI: begin
            // upper half comes straight from the extender
            cuif.extOp    = LUIEXT;
            cuif.memToReg = PORTB;
          end
          default: begin
            // LW
            cuif.extOp    = SIGNEXT;
            cuif.memToReg = DLOAD;
            cuif.dRen     = 1'b1;
          end
        endcase
      end
      SW: begin
        cuif.aluSrc = 1'b1;
        cuif.extOp  = SIGNEXT;
        cuif.dWen   = 1'b1;
      end
      BEQ, BNE: begin
        // compare by subtract, zero flag decides
        cuif.aluOp  = ALU_SUB;
        cuif.extOp  = SIGNEXT;
        cuif.opfunc = (cuif.instr.r.opcode == BEQ) ? OBEQ : OBNE;
      end
      J: cuif.opfunc = OJ;
      JAL: begin
        cuif.opfunc   = OJAL;
        cuif.regDst   = R31;
        cuif.memToReg = NPC;
        cuif.regWen   = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== src/registerFile.sv ====
// combinational reads, write on the CLK edge; no internal bypass so a same-cycle read sees old data
`timescale 1ns/1ps

module registerFile (
  input logic    CLK,
  input logic    rst,
  registerFileIf.rf rfif
);
  import cpuTypesPkg::*;

  word_t regs [2**REG_W];

  // register 0 is never written
  always_ff @(posedge CLK) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (rfif.wen && (rfif.wsel != '0)) begin
      regs[rfif.wsel] <= rfif.wdat;
    end
  end

  // two async read ports
  assign rfif.rdat1 = regs[rfif.rsel1];
  assign rfif.rdat2 = regs[rfif.rsel2];

  // r0 reads back zero on either port
  assert property (@(posedge CLK) disable iff (rst)
    (rfif.rsel1 == '0) |-> (rfif.rdat1 == '0))
    else $error("register 0 read nonzero on port 1");

  assert property (@(posedge CLK) disable iff (rst)
    (rfif.rsel2 == '0) |-> (rfif.rdat2 == '0))
    else $error("register 0 read nonzero on port 2");

endmodule

// ==== src/alu.sv ====
// no traps; overflow is only reported on the flag and only for ALU_ADD and ALU_SUB
`timescale 1ns/1ps

module alu (
  aluIf.alu aluif
);
  import cpuTypesPkg::*;

  always_comb begin
    case (aluif.aluOp)
      // shifts move port a by the low bits of port b
      ALU_SLL:  aluif.portO = aluif.portA << aluif.portB[SHAM_W-1:0];
      ALU_SRL:  aluif.portO = aluif.portA >> aluif.portB[SHAM_W-1:0];
      ALU_ADD:  aluif.portO = aluif.portA + aluif.portB;
      ALU_SUB:  aluif.portO = aluif.portA - aluif.portB;
      ALU_AND:  aluif.portO = aluif.portA & aluif.portB;
      ALU_OR:   aluif.portO = aluif.portA | aluif.portB;
      ALU_XOR:  aluif.portO = aluif.portA ^ aluif.portB;
      ALU_NOR:  aluif.portO = ~(aluif.portA | aluif.portB);
      ALU_SLT:  aluif.portO = word_t'($signed(aluif.portA) < $signed(aluif.portB));
      ALU_SLTU: aluif.portO = word_t'(aluif.portA < aluif.portB);
      default:  aluif.portO = '0;
    endcase
  end

  // signed overflow, add and subtract only
  always_comb begin
    case (aluif.aluOp)
      ALU_ADD: aluif.flagOverflow = (aluif.portA[WORD_W-1] == aluif.portB[WORD_W-1]) &&
                                    (aluif.portO[WORD_W-1] != aluif.portA[WORD_W-1]);
      ALU_SUB: aluif.flagOverflow = (aluif.portA[WORD_W-1] != aluif.portB[WORD_W-1]) &&
                                    (aluif.portO[WORD_W-1] != aluif.portA[WORD_W-1]);
      default: aluif.flagOverflow = 1'b0;
    endcase
  end

  assign aluif.flagNegative = aluif.portO[WORD_W-1];
  assign aluif.flagZero     = (aluif.portO == '0);

  // decode must never hand over an unlisted op
  assert property (@(posedge aluif.CLK)
    aluif.aluOp inside {ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
                        ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU})
    else $error("undefined alu op %0d", aluif.aluOp);

endmodule

// ==== src/requestUnit.sv ====
// one data request at a time; the caller must hold dRen and dWen low once the access is done
`timescale 1ns/1ps

module requestUnit (
  input  logic CLK,
  input  logic rst,
  input  logic ihit,
  input  logic dhit,
  input  logic dRen,
  input  logic dWen,
  output logic dmemREN,
  output logic dmemWEN
);

  // dhit closes the request, ihit opens one
  always_ff @(posedge CLK) begin
    if (rst) begin
      dmemREN <= 1'b0;
      dmemWEN <= 1'b0;
    end else if (dhit) begin
      dmemREN <= 1'b0;
      dmemWEN <= 1'b0;
    end else if (ihit) begin
      // latch what the fetched word asks for
      dmemREN <= dRen;
      dmemWEN <= dWen;
    end
  end

  // read and write never open together
  assert property (@(posedge CLK) disable iff (rst) !(dmemREN && dmemWEN))
    else $error("read and write requests both active");

endmodule

// ==== src/datapath.sv ====
// imemload must stay valid for imemaddr while the PC holds; memory ops take a second ihit to retire
`timescale 1ns/1ps

module datapath (
  input  logic               CLK,
  input  logic               rst,
  input  logic               ihit,
  input  cpuTypesPkg::word_t imemload,
  input  logic               dhit,
  input  cpuTypesPkg::word_t dmemload,
  output logic               halt,
  output logic               imemREN,
  output cpuTypesPkg::word_t imemaddr,
  output logic               dmemREN,
  output logic               dmemWEN,
  output logic               datomic,
  output cpuTypesPkg::word_t dmemstore,
  output cpuTypesPkg::word_t dmemaddr
);
  import cpuTypesPkg::*;

  instr_t   instr;
  word_t    pc, npc, branchTarget, jumpTarget, nextPc;
  word_t    extImm, operandB, writeData;
  regbits_t writeReg;
  logic     haltSticky, dataDone, dataWait, retire;

  registerFileIf rfBus ();
  aluIf          aluBus (CLK);
  controlUnitIf  cuBus ();

  controlUnit  cuInst  (.cuif(cuBus.cu));
  registerFile rfInst  (.CLK(CLK), .rst(rst), .rfif(rfBus.rf));
  alu          aluInst (.aluif(aluBus.alu));
  // access already served is masked off
  requestUnit  ruInst  (
    .CLK(CLK), .rst(rst), .ihit(ihit), .dhit(dhit),
    .dRen(cuBus.dRen && !dataDone), .dWen(cuBus.dWen && !dataDone),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN)
  );

  assign instr       = imemload;
  assign cuBus.instr = instr;

  // memory op waits until its access is served
  assign dataWait = (cuBus.dRen || cuBus.dWen) && !dataDone;
  assign retire   = ihit && !cuBus.halt && !haltSticky && !dataWait;

  always_ff @(posedge CLK) begin
    if (rst) begin
      pc         <= PC_INIT;
      haltSticky <= 1'b0;
      dataDone   <= 1'b0;
    end else begin
      if (retire) pc <= nextPc;
      if (ihit && cuBus.halt) haltSticky <= 1'b1;
      // served flag lives until the op retires
      if (retire) dataDone <= 1'b0;
      else if (dhit && (dmemREN || dmemWEN)) dataDone <= 1'b1;
    end
  end

  // extender
  always_comb begin
    case (cuBus.extOp)
      ZEROEXT: extImm = {{(WORD_W-IMM_W){1'b0}}, instr.i.imm};
      SIGNEXT: extImm = {{(WORD_W-IMM_W){instr.i.imm[IMM_W-1]}}, instr.i.imm};
      SHAMEXT: extImm = {{(WORD_W-SHAM_W){1'b0}}, instr.r.shamt};
      default: extImm = {instr.i.imm, {(WORD_W-IMM_W){1'b0}}};
    endcase
  end

  // register file hookup
  assign rfBus.rsel1 = instr.r.rs;
  assign rfBus.rsel2 = instr.r.rt;
  assign rfBus.wsel  = writeReg;
  assign rfBus.wdat  = writeData;
  assign rfBus.wen   = cuBus.regWen && retire;

  always_comb begin
    case (cuBus.regDst)
      RD:      writeReg = instr.r.rd;
      RT:      writeReg = instr.r.rt;
      R31:     writeReg = '1;
      default: writeReg = '0;
    endcase
  end

  // alu operands; shifts work on rt
  assign operandB     = cuBus.aluSrc ? extImm : rfBus.rdat2;
  assign aluBus.portA = (cuBus.extOp == SHAMEXT) ? rfBus.rdat2 : rfBus.rdat1;
  assign aluBus.portB = operandB;
  assign aluBus.aluOp = cuBus.aluOp;

  always_comb begin
    case (cuBus.memToReg)
      ALUO:    writeData = aluBus.portO;
      DLOAD:   writeData = dmemload;
      PORTB:   writeData = operandB;
      default: writeData = npc;
    endcase
  end

  // next pc
  assign npc          = pc + 32'd4;
  assign branchTarget = npc + {extImm[WORD_W-3:0], 2'b00};
  assign jumpTarget   = {npc[WORD_W-1:ADDR_W+2], instr.j.addr, 2'b00};

  always_comb begin
    case (cuBus.opfunc)
      OJR:     nextPc = rfBus.rdat1;
      OBEQ:    nextPc = aluBus.flagZero ? branchTarget : npc;
      OBNE:    nextPc = aluBus.flagZero ? npc : branchTarget;
      OJ, OJAL: nextPc = jumpTarget;
      default: nextPc = npc;
    endcase
  end

  // memory ports
  assign imemREN   = 1'b1;
  assign imemaddr  = pc;
  assign dmemaddr  = aluBus.portO;
  assign dmemstore = rfBus.rdat2;
  assign datomic   = 1'b0;
  assign halt      = haltSticky || (ihit && cuBus.halt);

  // word accesses only
  assert property (@(posedge CLK) disable iff (rst)
    (dmemREN || dmemWEN) |-> (dmemaddr[1:0] == 2'b00))
    else $error("unaligned data address %h", dmemaddr);

endmodule

// ==== src/cpuCore.sv ====
// single-cycle core; memory must withhold ihit while a data request is open
`timescale 1ns/1ps

module cpuCore (
  input  logic               CLK,
  input  logic               rst,
  // instruction side
  input  logic               ihit,
  input  cpuTypesPkg::word_t imemload,
  // data side
  input  logic               dhit,
  input  cpuTypesPkg::word_t dmemload,
  output logic               halt,
  output logic               imemREN,
  output cpuTypesPkg::word_t imemaddr,
  output logic               dmemREN,
  output logic               dmemWEN,
  output logic               datomic,
  output cpuTypesPkg::word_t dmemstore,
  output cpuTypesPkg::word_t dmemaddr
);

  // everything lives in the datapath
  datapath dpInst (
    .CLK(CLK),
    .rst(rst),
    .ihit(ihit),
    .imemload(imemload),
    .dhit(dhit),
    .dmemload(dmemload),
    .halt(halt),
    .imemREN(imemREN),
    .imemaddr(imemaddr),
    .dmemREN(dmemREN),
    .dmemWEN(dmemWEN),
    .datomic(datomic),
    .dmemstore(dmemstore),
    .dmemaddr(dmemaddr)
  );

endmodule

// ==== testbench/memoryModel.sv ====
// 512-word unified memory; ihit is withheld while a data request is open, and latency is 0 to 3
`timescale 1ns/1ps

module memoryModel (
  input  logic        CLK,
  input  logic        imemREN,
  input  logic [31:0] imemaddr,
  output logic        ihit,
  output logic [31:0] imemload,
  input  logic        dmemREN,
  input  logic        dmemWEN,
  input  logic [31:0] dmemaddr,
  input  logic [31:0] dmemstore,
  output logic        dhit,
  output logic [31:0] dmemload,
  input  logic [1:0]  latency,
  input  logic        loadEn,
  input  logic [8:0]  loadAddr,
  input  logic [31:0] loadData,
  input  logic        clearLog
);

  logic [31:0] mem [512];
  logic [31:0] heldLoad;
  logic [1:0]  waitCount;
  logic        dataReq;
  // store log, read by the testbench
  logic [31:0] logAddr [64];
  logic [31:0] logData [64];
  int          logCount;

  // fill pattern spreads every address bit over the word
  initial begin
    for (int i = 0; i < 512; i++) begin
      mem[i] <= (32'(i) * 32'h9e37_79b9) ^ 32'h0bad_f00d;
    end
    waitCount <= '0;
    logCount  <= 0;
  end

  assign dataReq  = dmemREN || dmemWEN;
  assign ihit     = imemREN && !dataReq;
  assign imemload = mem[imemaddr[10:2]];
  assign dhit     = dataReq && (waitCount == latency);
  // read data shows at dhit, then holds until the next request
  assign dmemload = dmemREN ? mem[dmemaddr[10:2]] : heldLoad;

  always @(posedge CLK) begin
    if (loadEn) mem[loadAddr] <= loadData;
    // latency counter restarts whenever no request is open
    if (!dataReq || dhit) waitCount <= '0;
    else waitCount <= waitCount + 2'd1;
    if (dmemREN && dhit) heldLoad <= mem[dmemaddr[10:2]];
    if (dmemWEN && dhit) mem[dmemaddr[10:2]] <= dmemstore;
    if (clearLog) begin
      logCount <= 0;
    end else if (dmemWEN && dhit && (logCount < 64)) begin
      logAddr[logCount] <= dmemaddr;
      logData[logCount] <= dmemstore;
      logCount          <= logCount + 1;
    end
  end

endmodule

// ==== testbench/cpuCoreTb.sv ====
// directed tests; every program ends in HALT and stores its results to word slots from 0x400
`timescale 1ns/1ps

module cpuCoreTb;
  import cpuTypesPkg::*;

  // six programs, 64 instructions, 5 cycles each is about 2000; doubled
  localparam int          timeoutCycles = 4000;
  localparam logic [15:0] dataBase      = 16'h0400;
  localparam regbits_t    regZero = 5'd0;
  localparam regbits_t    regA    = 5'd1;
  localparam regbits_t    regB    = 5'd2;
  localparam regbits_t    regRes  = 5'd3;
  localparam regbits_t    regLo   = 5'd4;
  localparam regbits_t    regHi   = 5'd5;
  localparam regbits_t    regLoad = 5'd6;
  localparam regbits_t    regMark = 5'd7;
  localparam regbits_t    regSum  = 5'd10;
  localparam regbits_t    regLink = 5'd31;

  logic  CLK = 1'b0;
  logic  rst, ihit, dhit, halt, imemREN, dmemREN, dmemWEN, datomic;
  word_t imemload, dmemload, imemaddr, dmemstore, dmemaddr;
  logic [1:0] latency;
  logic       loadEn, clearLog;
  logic [8:0] loadAddr;
  word_t      loadData;

  word_t prog [$];
  word_t expAddr [$];
  word_t expData [$];
  word_t lcgState = 32'hcec6_900d;
  int    cycles = 0;

  cpuCore UUT (
    .CLK(CLK), .rst(rst), .ihit(ihit), .imemload(imemload), .dhit(dhit),
    .dmemload(dmemload), .halt(halt), .imemREN(imemREN), .imemaddr(imemaddr),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN), .datomic(datomic),
    .dmemstore(dmemstore), .dmemaddr(dmemaddr)
  );

  memoryModel memInst (
    .CLK(CLK), .imemREN(imemREN), .imemaddr(imemaddr), .ihit(ihit), .imemload(imemload),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN), .dmemaddr(dmemaddr), .dmemstore(dmemstore),
    .dhit(dhit), .dmemload(dmemload), .latency(latency), .loadEn(loadEn),
    .loadAddr(loadAddr), .loadData(loadData), .clearLog(clearLog)
  );

  // 40 ns period
  always #20 CLK = ~CLK;

  task automatic reportFailure(string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= timeoutCycles) reportFailure("timeout: the tests did not finish in time");
  end

  task automatic checkWord(string name, string what, word_t expected, word_t actual);
    assert (actual === expected)
      else reportFailure($sformatf("** Error [%s] %s: expected %h, actual %h",
                                   name, what, expected, actual));
  endtask

  // lcg with the usual 32-bit constants
  function automatic word_t nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // less-than from the borrow of a 33-bit subtract
  // signed compare flips both sign bits first
  function automatic word_t lessThan(word_t a, word_t b, logic isSigned);
    logic [WORD_W:0] diff;
    word_t           bias;
    bias = isSigned ? 32'h8000_0000 : 32'h0000_0000;
    diff = {1'b0, a ^ bias} - {1'b0, b ^ bias};
    return word_t'(diff[WORD_W]);
  endfunction

  // encoders follow the MIPS field layout
  function automatic word_t rType(logic [5:0] funct, regbits_t rs, regbits_t rt,
                                  regbits_t rd, logic [4:0] shamt);
    return {6'b000000, rs, rt, rd, shamt, funct};
  endfunction

  function automatic word_t iType(logic [5:0] op, regbits_t rs, regbits_t rt,
                                  logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jType(logic [5:0] op, logic [25:0] addr);
    return {op, addr};
  endfunction

  function automatic logic [15:0] slotOffset(int slot);
    return dataBase + 16'(4 * slot);
  endfunction

  task automatic nextCycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic beginProgram();
    prog.delete();
    expAddr.delete();
    expData.delete();
  endtask

  task automatic emit(word_t w);
    prog.push_back(w);
  endtask

  // two words, LUI then ORI
  task automatic loadConst(regbits_t r, word_t v);
    emit(iType(LUI, regZero, r, v[31:16]));
    emit(iType(ORI, r, r, v[15:0]));
  endtask

  task automatic storeWord(regbits_t r, int slot);
    emit(iType(SW, regZero, r, slotOffset(slot)));
  endtask

  task automatic expectStore(int slot, word_t v);
    expAddr.push_back({16'h0000, slotOffset(slot)});
    expData.push_back(v);
  endtask

  task automatic storeResult(regbits_t r, int slot, word_t v);
    storeWord(r, slot);
    expectStore(slot, v);
  endtask

  task automatic rOp(logic [5:0] funct, regbits_t rs, regbits_t rt, int slot, word_t v);
    emit(rType(funct, rs, rt, regRes, 5'd0));
    storeResult(regRes, slot, v);
  endtask

  task automatic iOp(logic [5:0] op, logic [15:0] imm, int slot, word_t v);
    emit(iType(op, regA, regRes, imm));
    storeResult(regRes, slot, v);
  endtask

  // marker store, always to slot 0, so the log shows the path taken
  task automatic marker(logic [15:0] m, logic onPath);
    emit(iType(ADDIU, regZero, regMark, m));
    storeWord(regMark, 0);
    if (onPath) expectStore(0, {16'h0000, m});
  endtask

  // branch over a marker that only lands in the log when not taken
  task automatic branchOver(logic [5:0] op, regbits_t rs, regbits_t rt, logic taken,
                            logic [15:0] m);
    emit(iType(op, rs, rt, 16'd2));
    marker(m, !taken);
  endtask

  // core held in reset while the program goes in, then 2 more reset cycles
  task automatic startProgram();
    rst      = 1'b1;
    clearLog = 1'b1;
    for (int i = 0; i < prog.size(); i++) begin
      loadEn   = 1'b1;
      loadAddr = 9'(i);
      loadData = prog[i];
      nextCycle();
    end
    loadEn = 1'b0;
    repeat (2) nextCycle();
    rst      = 1'b0;
    clearLog = 1'b0;
  endtask

  task automatic waitForHalt();
    while (!halt) nextCycle();
  endtask

  task automatic checkStores(string name);
    checkWord(name, "store count", 32'(expData.size()), 32'(memInst.logCount));
    for (int i = 0; i < expData.size(); i++) begin
      checkWord(name, $sformatf("store %0d address", i), expAddr[i], memInst.logAddr[i]);
      checkWord(name, $sformatf("store %0d data", i), expData[i], memInst.logData[i]);
    end
  endtask

  task automatic runAndCheck(string name);
    startProgram();
    waitForHalt();
    checkStores(name);
  endtask

  task automatic testRType();
    word_t a, b;
    a = nextRand();
    b = nextRand();
    beginProgram();
    loadConst(regA, a);
    loadConst(regB, b);
    rOp(ADDU, regA, regB, 0, a + b);
    rOp(SUBU, regA, regB, 1, a - b);
    rOp(AND, regA, regB, 2, a & b);
    rOp(OR, regA, regB, 3, a | b);
    rOp(XOR, regA, regB, 4, a ^ b);
    rOp(NOR, regA, regB, 5, ~(a | b));
    rOp(SLT, regA, regB, 6, lessThan(a, b, 1'b1));
    rOp(SLTU, regA, regB, 7, lessThan(a, b, 1'b0));
    // most negative against most positive
    loadConst(regLo, 32'h8000_0000);
    loadConst(regHi, 32'h7fff_ffff);
    rOp(SLT, regLo, regHi, 8, 32'd1);
    rOp(SLTU, regLo, regHi, 9, 32'd0);
    rOp(SLT, regHi, regLo, 10, 32'd0);
    rOp(SLTU, regHi, regLo, 11, 32'd1);
    // write to r0 is dropped
    emit(rType(ADDU, regA, regB, regZero, 5'd0));
    storeResult(regZero, 12, 32'd0);
    emit(HALT_INSTR);
    latency = 2'd1;
    runAndCheck("rType");
  endtask

  task automatic testImmediates();
    word_t       a, r;
    logic [15:0] immNeg, immPos;
    logic [4:0]  sh;
    a      = nextRand();
    r      = nextRand();
    immNeg = r[15:0] | 16'h8000;
    immPos = r[31:16] & 16'h7fff;
    sh     = r[20:16];
    beginProgram();
    loadConst(regA, a);
    iOp(ADDIU, immNeg, 0, a + {{16{immNeg[15]}}, immNeg});
    iOp(ADDIU, immPos, 1, a + {16'h0000, immPos});
    iOp(ANDI, immNeg, 2, a & {16'h0000, immNeg});
    iOp(ORI, immNeg, 3, a | {16'h0000, immNeg});
    iOp(XORI, immNeg, 4, a ^ {16'h0000, immNeg});
    iOp(SLTI, immNeg, 5, lessThan(a, {{16{immNeg[15]}}, immNeg}, 1'b1));
    emit(iType(LUI, regZero, regRes, immPos));
    storeResult(regRes, 6, {immPos, 16'h0000});
    // shifts read rt
    emit(rType(SLL, regZero, regA, regRes, sh));
    storeResult(regRes, 7, a << sh);
    emit(rType(SRL, regZero, regA, regRes, sh));
    storeResult(regRes, 8, a >> sh);
    emit(HALT_INSTR);
    latency = 2'd0;
    runAndCheck("immediates");
  endtask

  task automatic testLoadStore();
    word_t v [4];
    word_t sum;
    int    lat, k;
    for (lat = 0; lat < 4; lat++) begin
      beginProgram();
      sum = '0;
      for (k = 0; k < 4; k++) begin
        v[k] = nextRand();
        loadConst(regA, v[k]);
        storeResult(regA, k, v[k]);
      end
      // read back, copy out, and accumulate
      for (k = 0; k < 4; k++) begin
        emit(iType(LW, regZero, regLoad, slotOffset(k)));
        storeResult(regLoad, 4 + k, v[k]);
        emit(rType(ADDU, regSum, regLoad, regSum, 5'd0));
        sum = sum + v[k];
      end
      storeResult(regSum, 8, sum);
      emit(HALT_INSTR);
      latency = 2'(lat);
      runAndCheck($sformatf("loadStore latency %0d", lat));
    end
  endtask

  task automatic testControlFlow();
    int    jalIdx;
    word_t link;
    beginProgram();
    emit(iType(ADDIU, regZero, regA, 16'd5));
    emit(iType(ADDIU, regZero, regB, 16'd5));
    emit(iType(ADDIU, regZero, regRes, 16'd6));
    branchOver(BEQ, regA, regB, 1'b1, 16'h0011);
    marker(16'h0021, 1'b1);
    branchOver(BEQ, regA, regRes, 1'b0, 16'h0012);
    marker(16'h0022, 1'b1);
    branchOver(BNE, regA, regRes, 1'b1, 16'h0013);
    marker(16'h0023, 1'b1);
    branchOver(BNE, regA, regB, 1'b0, 16'h0014);
    marker(16'h0024, 1'b1);
    // J lands just past the skipped marker
    emit(jType(J, 26'(prog.size() + 3)));
    marker(16'h0015, 1'b0);
    marker(16'h0025, 1'b1);
    // backward BNE, three trips
    emit(iType(ADDIU, regZero, regRes, 16'd3));
    emit(iType(ADDIU, regSum, regSum, 16'd1));
    emit(iType(ADDIU, regRes, regRes, 16'hffff));
    emit(iType(BNE, regRes, regZero, 16'hfffd));
    storeResult(regSum, 2, 32'd3);
    // subroutine sits after HALT
    jalIdx = prog.size();
    link   = 32'((jalIdx + 1) * 4);
    emit(jType(JAL, 26'(jalIdx + 5)));
    marker(16'h0027, 1'b0);
    storeWord(regLink, 1);
    emit(HALT_INSTR);
    marker(16'h0026, 1'b0);
    emit(rType(JR, regLink, regZero, regZero, 5'd0));
    expectStore(0, 32'h0000_0026);
    expectStore(0, 32'h0000_0027);
    expectStore(1, link);
    latency = 2'd2;
    runAndCheck("controlFlow");
  endtask

  task automatic testHalt();
    word_t haltAddr;
    int    count;
    beginProgram();
    emit(iType(ADDIU, regZero, regA, 16'h0055));
    storeResult(regA, 0, 32'h0000_0055);
    haltAddr = 32'(prog.size() * 4);
    emit(HALT_INSTR);
    // never reached
    emit(iType(ADDIU, regZero, regA, 16'h0066));
    storeWord(regA, 1);
    latency = 2'd1;
    startProgram();
    waitForHalt();
    count = memInst.logCount;
    for (int i = 0; i < 8; i++) begin
      checkWord("halt", "halt output", 32'd1, 32'(halt));
      checkWord("halt", "fetch address", haltAddr, imemaddr);
      checkWord("halt", "fetch enable", 32'd1, 32'(imemREN));
      checkWord("halt", "store count", 32'(count), 32'(memInst.logCount));
      checkWord("halt", "atomic output", 32'd0, 32'(datomic));
      nextCycle();
    end
    checkStores("halt");
  endtask

  task automatic testResetDuringRun();
    word_t a, b;
    a = nextRand();
    b = nextRand();
    beginProgram();
    loadConst(regA, a);
    storeResult(regA, 0, a);
    loadConst(regB, b);
    storeResult(regB, 1, b);
    rOp(ADDU, regA, regB, 2, a + b);
    emit(HALT_INSTR);
    latency = 2'd3;
    startProgram();
    // reset lands in the middle of an open store
    while (!dmemWEN) nextCycle();
    nextCycle();
    rst      = 1'b1;
    clearLog = 1'b1;
    nextCycle();
    checkWord("resetRun", "fetch address", PC_INIT, imemaddr);
    checkWord("resetRun", "read request", 32'd0, 32'(dmemREN));
    checkWord("resetRun", "write request", 32'd0, 32'(dmemWEN));
    nextCycle();
    rst      = 1'b0;
    clearLog = 1'b0;
    waitForHalt();
    checkStores("resetRun");
  endtask

  initial begin
    rst      = 1'b1;
    latency  = 2'd0;
    loadEn   = 1'b0;
    loadAddr = '0;
    loadData = '0;
    clearLog = 1'b1;
    testRType();
    testImmediates();
    testLoadStore();
    testControlFlow();
    testHalt();
    testResetDuringRun();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== cpuCore.f ====
src/cpuTypesPkg.sv
src/cpuIfs.sv
src/controlUnit.sv
src/registerFile.sv
src/alu.sv
src/requestUnit.sv
src/datapath.sv
src/cpuCore.sv
testbench/memoryModel.sv
testbench/cpuCoreTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run cpuCoreTb; the exit status carries pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module cpuCoreTb -f cpuCore.f -o cpuCoreSim \
  && ./obj_dir/cpuCoreSim \
  || exit 1
